// File: include/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// address map, every base is aligned to its region size.
`define SOC_IRAM_BASE 32'h0000_0000
`define SOC_IRAM_SIZE 32'h0000_1000

`define SOC_DRAM_BASE 32'h0001_0000
`define SOC_DRAM_SIZE 32'h0000_1000

`define SOC_TIMER_BASE 32'h0002_0000
`define SOC_TIMER_SIZE 32'h0000_0040

// ram depths in 32-bit words.
`define SOC_IRAM_WORDS 1024
`define SOC_DRAM_WORDS 1024

// timer register byte offsets.
`define SOC_TMR_MTIME_LO 32'h0000_0000
`define SOC_TMR_MTIME_HI 32'h0000_0004
`define SOC_TMR_CMP_LO 32'h0000_0008
`define SOC_TMR_CMP_HI 32'h0000_000C
`define SOC_TMR_CTRL 32'h0000_0010

`endif

// File: design/soc_pkg.sv
package soc_pkg;

  // where a request is sent, or whose response a master is waiting for.
  typedef enum logic [2:0] {
    TGT_IRAM  = 3'd0,
    TGT_DRAM  = 3'd1,
    TGT_TIMER = 3'd2,
    TGT_NONE  = 3'd4
  } target_e;

  // timer registers decoded from the word offset.
  typedef enum logic [2:0] {
    TREG_MTIME_LO = 3'd0,
    TREG_MTIME_HI = 3'd1,
    TREG_CMP_LO   = 3'd2,
    TREG_CMP_HI   = 3'd3,
    TREG_CTRL     = 3'd4,
    TREG_NONE     = 3'd7 // offset inside the region but unused.
  } timer_reg_e;

endpackage

// File: design/mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if;
  logic        valid;
  logic        instr;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [3:0]  wstrb; // all zero means a read.
  logic [31:0] rdata;
  logic        ready; // one-cycle pulse, rdata valid in the same cycle.

  modport master (
    output valid,
    output instr,
    output addr,
    output wdata,
    output wstrb,
    input  rdata,
    input  ready
  );

  modport slave (
    input  valid,
    input  instr,
    input  addr,
    input  wdata,
    input  wstrb,
    output rdata,
    output ready
  );
endinterface

// File: design/bus_crossbar.sv
`timescale 1ns/1ns
`include "soc_consts.svh"

module bus_crossbar (
  input logic     clk_pll,
  input logic     rst,
  mem_bus_if.slave  imem_bus,
  mem_bus_if.slave  dmem_bus,
  mem_bus_if.master iram_bus,
  mem_bus_if.master dram_bus,
  mem_bus_if.master timer_bus
);

  soc_pkg::target_e tgt_i, tgt_d;
  soc_pkg::target_e rel_i_q, rel_d_q;
  logic             nack_i_q, nack_d_q;
  logic             idle_i, idle_d;
  logic             acc_i, acc_d;
  logic             sel_d_iram, sel_d_dram, sel_d_timer;
  logic [32:0]      iram_resp, dram_resp, timer_resp;
  logic [32:0]      imem_resp, dmem_resp;

  function automatic soc_pkg::target_e decode(input logic [31:0] addr);
    if ((addr & ~(`SOC_IRAM_SIZE - 32'd1)) == `SOC_IRAM_BASE) return soc_pkg::TGT_IRAM;
    if ((addr & ~(`SOC_DRAM_SIZE - 32'd1)) == `SOC_DRAM_BASE) return soc_pkg::TGT_DRAM;
    if ((addr & ~(`SOC_TIMER_SIZE - 32'd1)) == `SOC_TIMER_BASE) return soc_pkg::TGT_TIMER;
    return soc_pkg::TGT_NONE;
  endfunction

  // a target is busy while either release register still waits on it.
  function automatic logic busy(input soc_pkg::target_e t, input soc_pkg::target_e ri,
                                input soc_pkg::target_e rd);
    return (t != soc_pkg::TGT_NONE) && ((t == ri) || (t == rd));
  endfunction

  function automatic logic [32:0] resp_sel(input soc_pkg::target_e rel, input logic nack,
                                           input logic [32:0] ir, input logic [32:0] dr,
                                           input logic [32:0] tr);
    case (rel)
      soc_pkg::TGT_IRAM:  return ir;
      soc_pkg::TGT_DRAM:  return dr;
      soc_pkg::TGT_TIMER: return tr;
      default:            return {nack, 32'h0}; // unmapped reads as zero.
    endcase
  endfunction

  assign tgt_i = decode(imem_bus.addr);
  assign tgt_d = decode(dmem_bus.addr);

  assign idle_i = (rel_i_q == soc_pkg::TGT_NONE) && !nack_i_q;
  assign idle_d = (rel_d_q == soc_pkg::TGT_NONE) && !nack_d_q;

  // dmem wins a same-target collision, imem keeps its request and retries.
  assign acc_d = dmem_bus.valid && idle_d && !busy(tgt_d, rel_i_q, rel_d_q);
  assign acc_i = imem_bus.valid && idle_i && !busy(tgt_i, rel_i_q, rel_d_q)
               && !(acc_d && (tgt_d == tgt_i) && (tgt_i != soc_pkg::TGT_NONE));

  assign sel_d_iram  = acc_d && (tgt_d == soc_pkg::TGT_IRAM);
  assign sel_d_dram  = acc_d && (tgt_d == soc_pkg::TGT_DRAM);
  assign sel_d_timer = acc_d && (tgt_d == soc_pkg::TGT_TIMER);

  assign iram_bus.valid = sel_d_iram || (acc_i && (tgt_i == soc_pkg::TGT_IRAM));
  assign iram_bus.instr = sel_d_iram ? dmem_bus.instr : imem_bus.instr;
  assign iram_bus.addr  = (sel_d_iram ? dmem_bus.addr : imem_bus.addr) ^ `SOC_IRAM_BASE;
  assign iram_bus.wdata = sel_d_iram ? dmem_bus.wdata : imem_bus.wdata;
  assign iram_bus.wstrb = sel_d_iram ? dmem_bus.wstrb : imem_bus.wstrb;

  assign dram_bus.valid = sel_d_dram || (acc_i && (tgt_i == soc_pkg::TGT_DRAM));
  assign dram_bus.instr = sel_d_dram ? dmem_bus.instr : imem_bus.instr;
  assign dram_bus.addr  = (sel_d_dram ? dmem_bus.addr : imem_bus.addr) ^ `SOC_DRAM_BASE;
  assign dram_bus.wdata = sel_d_dram ? dmem_bus.wdata : imem_bus.wdata;
  assign dram_bus.wstrb = sel_d_dram ? dmem_bus.wstrb : imem_bus.wstrb;

  assign timer_bus.valid = sel_d_timer || (acc_i && (tgt_i == soc_pkg::TGT_TIMER));
  assign timer_bus.instr = sel_d_timer ? dmem_bus.instr : imem_bus.instr;
  assign timer_bus.addr  = (sel_d_timer ? dmem_bus.addr : imem_bus.addr) ^ `SOC_TIMER_BASE;
  assign timer_bus.wdata = sel_d_timer ? dmem_bus.wdata : imem_bus.wdata;
  assign timer_bus.wstrb = sel_d_timer ? dmem_bus.wstrb : imem_bus.wstrb;

  assign iram_resp  = {iram_bus.ready, iram_bus.rdata};
  assign dram_resp  = {dram_bus.ready, dram_bus.rdata};
  assign timer_resp = {timer_bus.ready, timer_bus.rdata};

  assign imem_resp = resp_sel(rel_i_q, nack_i_q, iram_resp, dram_resp, timer_resp);
  assign dmem_resp = resp_sel(rel_d_q, nack_d_q, iram_resp, dram_resp, timer_resp);

  assign imem_bus.ready = imem_resp[32];
  assign imem_bus.rdata = imem_resp[31:0];
  assign dmem_bus.ready = dmem_resp[32];
  assign dmem_bus.rdata = dmem_resp[31:0];

  always_ff @(posedge clk_pll) begin
    if (!rst) begin
      rel_i_q  <= soc_pkg::TGT_NONE;
      rel_d_q  <= soc_pkg::TGT_NONE;
      nack_i_q <= 1'b0;
      nack_d_q <= 1'b0;
    end else begin
      nack_i_q <= acc_i && (tgt_i == soc_pkg::TGT_NONE);
      nack_d_q <= acc_d && (tgt_d == soc_pkg::TGT_NONE);
      if (acc_i) begin
        rel_i_q <= tgt_i;
      end else if (imem_resp[32]) begin
        rel_i_q <= soc_pkg::TGT_NONE; // response handed over.
      end
      if (acc_d) begin
        rel_d_q <= tgt_d;
      end else if (dmem_resp[32]) begin
        rel_d_q <= soc_pkg::TGT_NONE;
      end
    end
  end

endmodule

// File: design/sram_bank.sv
`timescale 1ns/1ns

module sram_bank #(
  parameter int WORDS = 1024
) (
  input logic      clk_pll,
  input logic      rst,
  mem_bus_if.slave bus
);

  localparam int AW = $clog2(WORDS);

  logic [31:0]   mem [WORDS];
  logic [AW-1:0] idx;

  assign idx = bus.addr[AW+1:2]; // word index inside the bank.

  always_ff @(posedge clk_pll) begin
    if (bus.valid) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.wstrb[b]) begin
          mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
      bus.rdata <= mem[idx]; // old word on a write, which nobody reads.
    end
  end

  always_ff @(posedge clk_pll) begin
    if (!rst) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= bus.valid;
    end
  end

endmodule

// File: design/timer_regs.sv
`timescale 1ns/1ns
`include "soc_consts.svh"

module timer_regs (
  input  logic        clk_pll,
  input  logic        rst,
  mem_bus_if.slave    bus,
  input  logic [63:0] mtime_i,
  output logic [63:0] cmp_o,
  output logic        enable_o,
  output logic [7:0]  prescale_o
);

  soc_pkg::timer_reg_e reg_sel;
  logic [31:0]         ctrl_word;
  logic [31:0]         ctrl_new;
  logic [31:0]         rd_word;

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wdata,
                                        input logic [3:0] wstrb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  always_comb begin
    case ({bus.addr[31:2], 2'b00})
      `SOC_TMR_MTIME_LO: reg_sel = soc_pkg::TREG_MTIME_LO;
      `SOC_TMR_MTIME_HI: reg_sel = soc_pkg::TREG_MTIME_HI;
      `SOC_TMR_CMP_LO:   reg_sel = soc_pkg::TREG_CMP_LO;
      `SOC_TMR_CMP_HI:   reg_sel = soc_pkg::TREG_CMP_HI;
      `SOC_TMR_CTRL:     reg_sel = soc_pkg::TREG_CTRL;
      default:           reg_sel = soc_pkg::TREG_NONE;
    endcase
  end

  assign ctrl_word = {16'h0, prescale_o, 7'h0, enable_o};
  assign ctrl_new  = merge(ctrl_word, bus.wdata, bus.wstrb);

  always_comb begin
    case (reg_sel)
      soc_pkg::TREG_MTIME_LO: rd_word = mtime_i[31:0];
      soc_pkg::TREG_MTIME_HI: rd_word = mtime_i[63:32];
      soc_pkg::TREG_CMP_LO:   rd_word = cmp_o[31:0];
      soc_pkg::TREG_CMP_HI:   rd_word = cmp_o[63:32];
      soc_pkg::TREG_CTRL:     rd_word = ctrl_word;
      default:                rd_word = 32'h0;
    endcase
  end

  always_ff @(posedge clk_pll) begin
    if (!rst) begin
      cmp_o      <= '1; // no interrupt until software sets a compare.
      enable_o   <= 1'b0;
      prescale_o <= 8'h0;
      bus.ready  <= 1'b0;
    end else begin
      bus.ready <= bus.valid;
      if (bus.valid) begin
        case (reg_sel)
          soc_pkg::TREG_CMP_LO: cmp_o[31:0]  <= merge(cmp_o[31:0], bus.wdata, bus.wstrb);
          soc_pkg::TREG_CMP_HI: cmp_o[63:32] <= merge(cmp_o[63:32], bus.wdata, bus.wstrb);
          soc_pkg::TREG_CTRL: begin
            enable_o   <= ctrl_new[0];
            prescale_o <= ctrl_new[15:8];
          end
          default: ; // mtime halves are read-only.
        endcase
      end
    end
  end

  always_ff @(posedge clk_pll) begin
    if (bus.valid) bus.rdata <= rd_word;
  end

endmodule

// File: design/timer_core.sv
`timescale 1ns/1ns

module timer_core (
  input  logic        clk_pll,
  input  logic        rst,
  input  logic [63:0] cmp_i,
  input  logic        enable_i,
  input  logic [7:0]  prescale_i,
  output logic [63:0] mtime_o,
  output logic        irq_o
);

  logic [7:0] presc_q;
  logic       tick;

  // one tick every prescale_i+1 cycles.
  assign tick = enable_i && (presc_q >= prescale_i);

  always_ff @(posedge clk_pll) begin
    if (!rst) begin
      presc_q <= 8'h0;
      mtime_o <= 64'h0;
      irq_o   <= 1'b0;
    end else begin
      if (!enable_i || tick) begin
        presc_q <= 8'h0;
      end else begin
        presc_q <= presc_q + 8'd1;
      end
      if (tick) begin
        mtime_o <= mtime_o + 64'd1;
      end
      irq_o <= enable_i && (mtime_o >= cmp_i);
    end
  end

endmodule

// File: design/soc_fabric.sv
`timescale 1ns/1ns
`include "soc_consts.svh"

module soc_fabric (
  input  logic        clk_pll,
  input  logic        rst,
  input  logic        imem_valid_i,
  input  logic        imem_instr_i,
  input  logic [31:0] imem_addr_i,
  input  logic [31:0] imem_wdata_i,
  input  logic [3:0]  imem_wstrb_i,
  output logic [31:0] imem_rdata_o,
  output logic        imem_ready_o,
  input  logic        dmem_valid_i,
  input  logic        dmem_instr_i,
  input  logic [31:0] dmem_addr_i,
  input  logic [31:0] dmem_wdata_i,
  input  logic [3:0]  dmem_wstrb_i,
  output logic [31:0] dmem_rdata_o,
  output logic        dmem_ready_o,
  output logic        timer_irq_o
);

  mem_bus_if imem_bus ();
  mem_bus_if dmem_bus ();
  mem_bus_if iram_bus ();
  mem_bus_if dram_bus ();
  mem_bus_if timer_bus ();

  logic [63:0] cmp;
  logic [63:0] mtime;
  logic        enable;
  logic [7:0]  prescale;

  assign imem_bus.valid = imem_valid_i;
  assign imem_bus.instr = imem_instr_i;
  assign imem_bus.addr  = imem_addr_i;
  assign imem_bus.wdata = imem_wdata_i;
  assign imem_bus.wstrb = imem_wstrb_i;
  assign imem_rdata_o   = imem_bus.rdata;
  assign imem_ready_o   = imem_bus.ready;

  assign dmem_bus.valid = dmem_valid_i;
  assign dmem_bus.instr = dmem_instr_i;
  assign dmem_bus.addr  = dmem_addr_i;
  assign dmem_bus.wdata = dmem_wdata_i;
  assign dmem_bus.wstrb = dmem_wstrb_i;
  assign dmem_rdata_o   = dmem_bus.rdata;
  assign dmem_ready_o   = dmem_bus.ready;

  bus_crossbar i_xbar (
    .clk_pll(clk_pll), .rst(rst),
    .imem_bus(imem_bus.slave), .dmem_bus(dmem_bus.slave),
    .iram_bus(iram_bus.master), .dram_bus(dram_bus.master), .timer_bus(timer_bus.master)
  );

  sram_bank #(.WORDS(`SOC_IRAM_WORDS)) i_iram (.clk_pll(clk_pll), .rst(rst), .bus(iram_bus.slave));
  sram_bank #(.WORDS(`SOC_DRAM_WORDS)) i_dram (.clk_pll(clk_pll), .rst(rst), .bus(dram_bus.slave));

  timer_regs i_tregs (
    .clk_pll(clk_pll), .rst(rst), .bus(timer_bus.slave), .mtime_i(mtime),
    .cmp_o(cmp), .enable_o(enable), .prescale_o(prescale)
  );

  timer_core i_tcore (
    .clk_pll(clk_pll), .rst(rst), .cmp_i(cmp), .enable_i(enable), .prescale_i(prescale),
    .mtime_o(mtime), .irq_o(timer_irq_o)
  );

endmodule

// File: testbench/soc_properties.sv
`timescale 1ns/1ns

module soc_properties (
  input logic clk_pll,
  input logic rst,
  input logic imem_valid_i,
  input logic imem_ready_o,
  input logic dmem_valid_i,
  input logic dmem_ready_o,
  input logic enable_i,
  input logic timer_irq_o
);

  // ready is a single pulse and only answers a held request.
  a_imem_pulse: assert property (@(posedge clk_pll) disable iff (!rst)
    imem_ready_o |-> imem_valid_i ##1 !imem_ready_o)
    else $error("imem ready is not a one-cycle pulse under valid");

  a_dmem_pulse: assert property (@(posedge clk_pll) disable iff (!rst)
    dmem_ready_o |-> dmem_valid_i ##1 !dmem_ready_o)
    else $error("dmem ready is not a one-cycle pulse under valid");

  a_no_ready_after_reset: assert property (@(posedge clk_pll)
    $rose(rst) |-> !imem_ready_o && !dmem_ready_o)
    else $error("ready seen right after reset release");

  // irq is registered, so it may trail a cleared enable by one cycle.
  a_irq_needs_enable: assert property (@(posedge clk_pll) disable iff (!rst)
    (!enable_i && !$past(enable_i)) |-> !timer_irq_o)
    else $error("timer interrupt high while the timer is disabled");

endmodule

bind soc_fabric soc_properties i_props (
  .clk_pll(clk_pll), .rst(rst),
  .imem_valid_i(imem_valid_i), .imem_ready_o(imem_ready_o),
  .dmem_valid_i(dmem_valid_i), .dmem_ready_o(dmem_ready_o),
  .enable_i(enable), .timer_irq_o(timer_irq_o)
);

// File: testbench/soc_tb.sv
`timescale 1ns/1ns
`include "soc_consts.svh"

module soc_tb;
  // transactions per test, in test order.
  localparam int NUM_TX = 208 + 48 + 60 + 28 + 17 + 6;
  localparam int TIMEOUT_NS = (NUM_TX * 20 + 1000) * 4;

  logic clk_pll, rst;
  logic imem_valid_i, imem_instr_i, dmem_valid_i, dmem_instr_i;
  logic [31:0] imem_addr_i, imem_wdata_i, dmem_addr_i, dmem_wdata_i;
  logic [3:0] imem_wstrb_i, dmem_wstrb_i;
  logic [31:0] imem_rdata_o, dmem_rdata_o;
  logic imem_ready_o, dmem_ready_o, timer_irq_o;

  logic [31:0] iram_m [1024];
  logic [31:0] dram_m [1024];
  logic [63:0] cmp_m;
  logic [31:0] ctrl_m;
  int checks, errors;

  soc_fabric i_dut (.*);

  initial begin
    clk_pll = 1'b0;
    forever #2 clk_pll = ~clk_pll;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired, a transfer never completed");
    $display(">>> FAIL");
    $finish;
  end

  function automatic soc_pkg::target_e expect_target(input logic [31:0] a);
    if (a >= `SOC_IRAM_BASE && a < `SOC_IRAM_BASE + `SOC_IRAM_SIZE) return soc_pkg::TGT_IRAM;
    if (a >= `SOC_DRAM_BASE && a < `SOC_DRAM_BASE + `SOC_DRAM_SIZE) return soc_pkg::TGT_DRAM;
    if (a >= `SOC_TIMER_BASE && a < `SOC_TIMER_BASE + `SOC_TIMER_SIZE) return soc_pkg::TGT_TIMER;
    return soc_pkg::TGT_NONE;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] a);
    logic [31:0] off;
    off = a - `SOC_TIMER_BASE;
    case (expect_target(a))
      soc_pkg::TGT_IRAM: return iram_m[a[11:2]];
      soc_pkg::TGT_DRAM: return dram_m[a[11:2]];
      soc_pkg::TGT_TIMER: begin
        if (off[5:2] == 4'd2) return cmp_m[31:0];
        if (off[5:2] == 4'd3) return cmp_m[63:32];
        if (off[5:2] == 4'd4) return ctrl_m;
        return 32'h0;
      end
      default: return 32'h0;
    endcase
  endfunction

  task automatic model_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    logic [31:0] w;
    w = model_read(a);
    for (int b = 0; b < 4; b++) begin
      if (s[b]) w[8*b +: 8] = d[8*b +: 8];
    end
    case (expect_target(a))
      soc_pkg::TGT_IRAM: iram_m[a[11:2]] = w;
      soc_pkg::TGT_DRAM: dram_m[a[11:2]] = w;
      soc_pkg::TGT_TIMER: begin
        if (a[5:2] == 4'd2) cmp_m[31:0] = w;
        if (a[5:2] == 4'd3) cmp_m[63:32] = w;
        if (a[5:2] == 4'd4) ctrl_m = {16'h0, w[15:8], 7'h0, w[0]}; // only enable and prescale.
      end
      default: ;
    endcase
  endtask

  task automatic check_rdata(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got 0x%08h expected 0x%08h", what, got, exp);
    end
  endtask

  task automatic check_target(input string what, input soc_pkg::target_e got,
                              input soc_pkg::target_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got 0x%0h expected 0x%0h", what, got, exp);
    end
  endtask

  task automatic check_irq(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL timer_irq_o got 0x%0h expected 0x%0h", got, exp);
    end
  endtask

  // one full valid/ready handshake on either master.
  task automatic xfer(input bit use_d, input logic [31:0] a, input logic [31:0] d,
                      input logic [3:0] s, output logic [31:0] rd, output int waited);
    bit got;
    soc_pkg::target_e rel;
    string rel_name;
    got = 0;
    waited = 0;
    @(posedge clk_pll);
    #1;
    if (use_d) begin
      dmem_valid_i = 1'b1;
      dmem_addr_i = a;
      dmem_wdata_i = d;
      dmem_wstrb_i = s;
      rel_name = "rel_d_q";
    end else begin
      imem_valid_i = 1'b1;
      imem_addr_i = a;
      imem_wdata_i = d;
      imem_wstrb_i = s;
      rel_name = "rel_i_q";
    end
    while (!got) begin
      @(posedge clk_pll);
      waited++;
      @(negedge clk_pll);
      got = use_d ? dmem_ready_o : imem_ready_o;
    end
    rd = use_d ? dmem_rdata_o : imem_rdata_o;
    rel = use_d ? i_dut.i_xbar.rel_d_q : i_dut.i_xbar.rel_i_q;
    check_target(rel_name, rel, expect_target(a));
    @(posedge clk_pll);
    #1;
    if (use_d) dmem_valid_i = 1'b0;
    else imem_valid_i = 1'b0;
  endtask

  task automatic write_word(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    logic [31:0] rd;
    int w;
    xfer(1'b1, a, d, s, rd, w);
    model_write(a, d, s);
  endtask

  task automatic read_check(input bit use_d, input logic [31:0] a, input string what);
    logic [31:0] rd;
    int w;
    xfer(use_d, a, 32'h0, 4'h0, rd, w);
    check_rdata(what, rd, model_read(a));
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - errs_before);
  endtask

  task automatic wait_irq(input int bound);
    int n;
    n = 0;
    while (!timer_irq_o && n < bound) begin
      @(negedge clk_pll);
      n++;
    end
    if (!timer_irq_o) $display("timer interrupt did not rise within %0d cycles", bound);
    check_irq(timer_irq_o, 1'b1);
  endtask

  initial begin
    logic [31:0] a, a2, rd, prev, m;
    int e0, w;
    bit sel;
    void'($urandom(44243));
    rst = 1'b0;
    {imem_valid_i, imem_instr_i, dmem_valid_i, dmem_instr_i} = 4'b0100;
    {imem_addr_i, imem_wdata_i, dmem_addr_i, dmem_wdata_i} = '0;
    {imem_wstrb_i, dmem_wstrb_i} = '0;
    cmp_m = '1;
    ctrl_m = '0;
    checks = 0;
    errors = 0;
    repeat (5) @(posedge clk_pll);
    #1 rst = 1'b1;

    e0 = errors;
    for (int i = 0; i < 64; i++) begin
      write_word(`SOC_IRAM_BASE + 4 * i, $urandom, 4'hF);
      write_word(`SOC_DRAM_BASE + 4 * i, $urandom, 4'hF);
    end
    repeat (40) begin
      sel = $urandom_range(0, 1);
      write_word((sel ? `SOC_DRAM_BASE : `SOC_IRAM_BASE) + 4 * $urandom_range(0, 63),
                 $urandom, 4'($urandom_range(1, 15)));
    end
    repeat (40) begin
      sel = $urandom_range(0, 1);
      a = (sel ? `SOC_DRAM_BASE : `SOC_IRAM_BASE) + 4 * $urandom_range(0, 63);
      xfer(1'b1, a, 32'h0, 4'h0, rd, w);
      check_rdata("dmem_rdata_o", rd, model_read(a));
      if (w != 1) begin
        errors++;
        $display("dmem ready came %0d cycles after valid instead of 1", w);
      end
    end
    report_test("ram write and read back", e0);

    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      write_word(`SOC_IRAM_BASE + 4 * i, $urandom, 4'hF);
      read_check(1'b0, `SOC_IRAM_BASE + 4 * i, "imem_rdata_o");
      read_check(1'b0, `SOC_DRAM_BASE + 4 * (i + 16), "imem_rdata_o");
    end
    report_test("fetch through imem", e0);

    e0 = errors;
    repeat (30) begin
      sel = $urandom_range(0, 1);
      a = (sel ? `SOC_DRAM_BASE : `SOC_IRAM_BASE) + 4 * $urandom_range(0, 63);
      sel = $urandom_range(0, 2) == 0;
      a2 = sel ? `SOC_TIMER_BASE + 4 * $urandom_range(2, 4) : {a[31:8], 8'($urandom)} & ~32'h3;
      fork
        read_check(1'b0, a, "imem_rdata_o");
        read_check(1'b1, a2, "dmem_rdata_o");
      join
    end
    report_test("concurrent masters", e0);

    e0 = errors;
    repeat (6) begin
      read_check(1'b1, 32'h0003_0000 + 4 * $urandom_range(0, 255), "dmem_rdata_o");
      read_check(1'b0, 32'h0000_2000 + 4 * $urandom_range(0, 255), "imem_rdata_o");
    end
    // these alias the first iram words if the upper address bits were ignored.
    for (int i = 0; i < 8; i++) write_word(32'h0000_2000 + 4 * i, $urandom, 4'hF);
    for (int i = 0; i < 8; i++) read_check(1'b1, `SOC_IRAM_BASE + 4 * i, "dmem_rdata_o");
    report_test("unmapped access", e0);

    e0 = errors;
    write_word(`SOC_TIMER_BASE + `SOC_TMR_CMP_LO, $urandom, 4'hF);
    write_word(`SOC_TIMER_BASE + `SOC_TMR_CMP_HI, $urandom, 4'hF);
    read_check(1'b1, `SOC_TIMER_BASE + `SOC_TMR_CMP_LO, "cmp_lo");
    read_check(1'b1, `SOC_TIMER_BASE + `SOC_TMR_CMP_HI, "cmp_hi");
    write_word(`SOC_TIMER_BASE + `SOC_TMR_CTRL, $urandom & ~32'h1, 4'hF);
    read_check(1'b1, `SOC_TIMER_BASE + `SOC_TMR_CTRL, "ctrl");
    xfer(1'b1, `SOC_TIMER_BASE + `SOC_TMR_MTIME_LO, 32'h0, 4'h0, rd, w);
    check_rdata("mtime_lo", rd, 32'h0);
    check_irq(timer_irq_o, 1'b0);
    write_word(`SOC_TIMER_BASE + `SOC_TMR_CTRL, 32'h0000_0201, 4'h3);
    read_check(1'b1, `SOC_TIMER_BASE + `SOC_TMR_CTRL, "ctrl");
    prev = 32'h0;
    repeat (8) begin
      xfer(1'b1, `SOC_TIMER_BASE + `SOC_TMR_MTIME_LO, 32'h0, 4'h0, rd, w);
      if (rd < prev) begin
        errors++;
        $display("mtime went backwards from 0x%08h to 0x%08h", prev, rd);
      end
      prev = rd;
    end
    report_test("timer registers", e0);

    e0 = errors;
    xfer(1'b1, `SOC_TIMER_BASE + `SOC_TMR_MTIME_LO, 32'h0, 4'h0, m, w);
    write_word(`SOC_TIMER_BASE + `SOC_TMR_CMP_LO, m + 32'd6, 4'hF);
    write_word(`SOC_TIMER_BASE + `SOC_TMR_CMP_HI, 32'h0, 4'hF);
    wait_irq((6 + 2) * 3);
    write_word(`SOC_TIMER_BASE + `SOC_TMR_CMP_HI, 32'hFFFF_FFFF, 4'hF);
    repeat (3) @(negedge clk_pll);
    check_irq(timer_irq_o, 1'b0);
    write_word(`SOC_TIMER_BASE + `SOC_TMR_CMP_HI, 32'h0, 4'hF);
    wait_irq((6 + 2) * 3);
    write_word(`SOC_TIMER_BASE + `SOC_TMR_CTRL, 32'h0, 4'h1);
    repeat (3) @(negedge clk_pll);
    check_irq(timer_irq_o, 1'b0);
    report_test("timer interrupt", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+include
design/soc_pkg.sv
design/mem_bus_if.sv
design/bus_crossbar.sv
design/sram_bank.sv
design/timer_regs.sv
design/timer_core.sv
design/soc_fabric.sv
testbench/soc_properties.sv
testbench/soc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the fabric testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module soc_tb -f vlog.f -o soc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/soc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx '>>> PASS' sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
